//--- design/hci_cfg_pkg.sv
`default_nettype none

package hci_cfg_pkg;

  // memory organization
  // eight word-interleaved banks of 256 words each
  localparam int unsigned NB_BANKS   = 8;
  localparam int unsigned BANK_SEL_W = 3;
  localparam int unsigned BANK_DEPTH = 256;
  localparam int unsigned ROW_W      = 8;

  // bank word and its byte enables
  localparam int unsigned WORD_W = 32;
  localparam int unsigned BE_W   = 4;

  // wide accelerator port, four 32-bit lanes per access
  localparam int unsigned NB_LANES = 4;
  localparam int unsigned WIDE_DW  = 128;
  localparam int unsigned WIDE_BW  = 16;

  // byte address on both ports
  localparam int unsigned ADDR_W = 32;

  // address split: bits 1:0 byte in word, then bank select, then row
  localparam int unsigned BANK_LSB = 2;
  localparam int unsigned ROW_LSB  = BANK_LSB + BANK_SEL_W;

endpackage

`default_nettype wire

//--- design/hci_types_pkg.sv
`default_nettype none

package hci_types_pkg;

  // access opcode, same encoding on the wide and the narrow port
  typedef enum logic {
    HCI_READ  = 1'b0,
    HCI_WRITE = 1'b1
  } hci_op_e;

  // owner of the next bank conflict
  // log is the narrow core port, hwpe the wide accelerator port
  typedef enum logic {
    PRIO_LOG  = 1'b0,
    PRIO_HWPE = 1'b1
  } arb_prio_e;

endpackage

`default_nettype wire

//--- design/tcdm_bank.sv
`default_nettype none
`timescale 1ns/1ps

module tcdm_bank (
  input  wire logic                          clk_i,
  input  wire logic                          req_i,
  input  wire logic                          we_i,
  input  wire logic [hci_cfg_pkg::ROW_W-1:0]  row_i,
  input  wire logic [hci_cfg_pkg::BE_W-1:0]   be_i,
  input  wire logic [hci_cfg_pkg::WORD_W-1:0] wdata_i,
  output logic      [hci_cfg_pkg::WORD_W-1:0] rdata_o
);

  // word array, one entry per row
  logic [hci_cfg_pkg::WORD_W-1:0] mem [hci_cfg_pkg::BANK_DEPTH];

  // single port
  // write on req with we, byte lanes gated by be
  // read registers the addressed word, valid the next cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < hci_cfg_pkg::BE_W; i++) begin
          if (be_i[i]) begin
            mem[row_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[row_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/hci_router.sv
`default_nettype none
`timescale 1ns/1ps

module hci_router (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    clear_i,

  // wide accelerator port
  input  wire logic                    hwpe_req_i,
  input  wire hci_types_pkg::hci_op_e  hwpe_op_i,
  input  wire logic [hci_cfg_pkg::ADDR_W-1:0]  hwpe_add_i,
  input  wire logic [hci_cfg_pkg::WIDE_BW-1:0] hwpe_be_i,
  input  wire logic [hci_cfg_pkg::WIDE_DW-1:0] hwpe_data_i,
  output logic                         hwpe_gnt_o,
  output logic                         hwpe_r_valid_o,
  output logic [hci_cfg_pkg::WIDE_DW-1:0]      hwpe_r_data_o,

  // all-or-nothing grant from the bank arbiter
  input  wire logic                    grant_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_rdata_i,

  // per-bank request vectors towards the arbiter
  output logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_req_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] bank_row_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  bank_be_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_wdata_o,
  output hci_types_pkg::hci_op_e       bank_op_o
);

  // bank of lane 0 and row shared by the non-wrapping lanes
  logic [hci_cfg_pkg::BANK_SEL_W-1:0] bank_offset;
  logic [hci_cfg_pkg::ROW_W-1:0]      base_row;

  // response side state
  logic                               gnt_q;
  logic [hci_cfg_pkg::BANK_SEL_W-1:0] bank_offset_q;

  assign bank_offset = hwpe_add_i[hci_cfg_pkg::ROW_LSB-1:hci_cfg_pkg::BANK_LSB];
  assign base_row    = hwpe_add_i[hci_cfg_pkg::ROW_LSB+hci_cfg_pkg::ROW_W-1:hci_cfg_pkg::ROW_LSB];

  // op is common to all lanes
  assign bank_op_o = hwpe_op_i;

  // rotate lanes onto banks
  // lane k sits on bank (offset + k) mod 8, row moves on when the sum wraps
  always_comb begin : lane_rotate
    logic [hci_cfg_pkg::BANK_SEL_W:0]   lane_sum;
    logic [hci_cfg_pkg::BANK_SEL_W-1:0] lane_bank;
    bank_req_o   = '0;
    bank_row_o   = '0;
    bank_be_o    = '0;
    bank_wdata_o = '0;
    for (int unsigned k = 0; k < hci_cfg_pkg::NB_LANES; k++) begin
      lane_sum  = (hci_cfg_pkg::BANK_SEL_W+1)'(bank_offset)
                + (hci_cfg_pkg::BANK_SEL_W+1)'(k);
      lane_bank = lane_sum[hci_cfg_pkg::BANK_SEL_W-1:0];
      // unused banks keep req low
      bank_req_o[lane_bank]   = hwpe_req_i;
      // carry out of the bank field is the wrap into the next row
      bank_row_o[lane_bank]   = base_row
                              + hci_cfg_pkg::ROW_W'(lane_sum[hci_cfg_pkg::BANK_SEL_W]);
      bank_be_o[lane_bank]    = hwpe_be_i[k*hci_cfg_pkg::BE_W +: hci_cfg_pkg::BE_W];
      bank_wdata_o[lane_bank] = hwpe_data_i[k*hci_cfg_pkg::WORD_W +: hci_cfg_pkg::WORD_W];
    end
  end

  // the arbiter never splits a wide access, one grant covers every lane
  // gnt only where req is high
  assign hwpe_gnt_o = hwpe_req_i & grant_i;

  // r_valid follows a granted access by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= hwpe_gnt_o;
    end
  end

  // offset of the granted access, used to undo the rotation
  always_ff @(posedge clk_i) begin
    if (hwpe_gnt_o) begin
      bank_offset_q <= bank_offset;
    end
  end

  assign hwpe_r_valid_o = gnt_q;

  // rotate the bank read data back into lane order
  always_comb begin : rdata_rotate
    logic [hci_cfg_pkg::BANK_SEL_W-1:0] rd_bank;
    hwpe_r_data_o = '0;
    for (int unsigned k = 0; k < hci_cfg_pkg::NB_LANES; k++) begin
      // modulo 8 comes from the field width
      rd_bank = bank_offset_q + hci_cfg_pkg::BANK_SEL_W'(k);
      hwpe_r_data_o[k*hci_cfg_pkg::WORD_W +: hci_cfg_pkg::WORD_W] = bank_rdata_i[rd_bank];
    end
  end

endmodule

`default_nettype wire

//--- design/hci_log_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module hci_log_decoder (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    clear_i,

  // narrow core port
  input  wire logic                    log_req_i,
  input  wire hci_types_pkg::hci_op_e  log_op_i,
  input  wire logic [hci_cfg_pkg::ADDR_W-1:0] log_add_i,
  input  wire logic [hci_cfg_pkg::BE_W-1:0]   log_be_i,
  input  wire logic [hci_cfg_pkg::WORD_W-1:0] log_data_i,
  output logic                         log_gnt_o,
  output logic                         log_r_valid_o,
  output logic [hci_cfg_pkg::WORD_W-1:0]      log_r_data_o,

  // grant from the bank arbiter
  input  wire logic                    grant_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_rdata_i,

  // per-bank request vectors towards the arbiter
  output logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_req_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] bank_row_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  bank_be_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_wdata_o,
  output hci_types_pkg::hci_op_e       bank_op_o
);

  logic [hci_cfg_pkg::BANK_SEL_W-1:0] bank_sel;
  logic [hci_cfg_pkg::ROW_W-1:0]      row;
  logic                               gnt_q;
  logic [hci_cfg_pkg::BANK_SEL_W-1:0] bank_sel_q;

  assign bank_sel = log_add_i[hci_cfg_pkg::ROW_LSB-1:hci_cfg_pkg::BANK_LSB];
  assign row      = log_add_i[hci_cfg_pkg::ROW_LSB+hci_cfg_pkg::ROW_W-1:hci_cfg_pkg::ROW_LSB];

  // one-hot request on the addressed bank
  // row, be and data go to every bank, the arbiter only looks where req is set
  always_comb begin
    bank_req_o = '0;
    bank_req_o[bank_sel] = log_req_i;
    for (int unsigned b = 0; b < hci_cfg_pkg::NB_BANKS; b++) begin
      bank_row_o[b]   = row;
      bank_be_o[b]    = log_be_i;
      bank_wdata_o[b] = log_data_i;
    end
  end

  assign bank_op_o = log_op_i;
  assign log_gnt_o = log_req_i & grant_i;

  // response one cycle after gnt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= log_gnt_o;
    end
  end

  // remember which bank answers
  always_ff @(posedge clk_i) begin
    if (log_gnt_o) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign log_r_valid_o = gnt_q;
  assign log_r_data_o  = bank_rdata_i[bank_sel_q];

endmodule

`default_nettype wire

//--- design/hci_bank_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module hci_bank_arbiter (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    clear_i,

  // wide port bank vectors from the router
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0]                         hwpe_req_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] hwpe_row_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  hwpe_be_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] hwpe_wdata_i,
  input  wire hci_types_pkg::hci_op_e  hwpe_op_i,

  // narrow port bank vectors from the decoder
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0]                         log_req_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] log_row_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  log_be_i,
  input  wire logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] log_wdata_i,
  input  wire hci_types_pkg::hci_op_e  log_op_i,

  output logic                         hwpe_grant_o,
  output logic                         log_grant_o,

  // merged bank inputs
  output logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_req_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_we_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] bank_row_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  bank_be_o,
  output logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_wdata_o
);

  logic                            hwpe_any;
  logic                            log_any;
  logic                            conflict;
  logic [hci_cfg_pkg::NB_BANKS-1:0] sel_hwpe;
  logic [hci_cfg_pkg::NB_BANKS-1:0] sel_log;
  hci_types_pkg::arb_prio_e        prio_q;

  assign hwpe_any = |hwpe_req_i;
  assign log_any  = |log_req_i;

  // any bank wanted by both ports in this cycle
  assign conflict = |(hwpe_req_i & log_req_i);

  // all-or-nothing for the wide port
  // without a conflict both ports go through, otherwise the flag decides
  assign hwpe_grant_o = hwpe_any & (~conflict | (prio_q == hci_types_pkg::PRIO_HWPE));
  assign log_grant_o  = log_any  & (~conflict | (prio_q == hci_types_pkg::PRIO_LOG));

  // per bank owner, at most one of the two is set
  assign sel_hwpe = hwpe_req_i & {hci_cfg_pkg::NB_BANKS{hwpe_grant_o}};
  assign sel_log  = log_req_i  & {hci_cfg_pkg::NB_BANKS{log_grant_o}};

  always_comb begin
    for (int unsigned b = 0; b < hci_cfg_pkg::NB_BANKS; b++) begin
      bank_req_o[b] = sel_hwpe[b] | sel_log[b];
      if (sel_hwpe[b]) begin
        bank_we_o[b]    = (hwpe_op_i == hci_types_pkg::HCI_WRITE);
        bank_row_o[b]   = hwpe_row_i[b];
        bank_be_o[b]    = hwpe_be_i[b];
        bank_wdata_o[b] = hwpe_wdata_i[b];
      end else begin
        // narrow fields also sit on idle banks, harmless with req low
        bank_we_o[b]    = sel_log[b] & (log_op_i == hci_types_pkg::HCI_WRITE);
        bank_row_o[b]   = log_row_i[b];
        bank_be_o[b]    = log_be_i[b];
        bank_wdata_o[b] = log_wdata_i[b];
      end
    end
  end

  // priority hands over to the loser after every conflict cycle
  // so a port that lost once wins the next clash
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= hci_types_pkg::PRIO_LOG;
    end else if (clear_i) begin
      prio_q <= hci_types_pkg::PRIO_LOG;
    end else if (conflict) begin
      if (prio_q == hci_types_pkg::PRIO_LOG) begin
        prio_q <= hci_types_pkg::PRIO_HWPE;
      end else begin
        prio_q <= hci_types_pkg::PRIO_LOG;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/hci_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module hci_subsystem (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    clear_i,

  // wide accelerator port
  input  wire logic                    hwpe_req_i,
  input  wire hci_types_pkg::hci_op_e  hwpe_op_i,
  input  wire logic [hci_cfg_pkg::ADDR_W-1:0]  hwpe_add_i,
  input  wire logic [hci_cfg_pkg::WIDE_BW-1:0] hwpe_be_i,
  input  wire logic [hci_cfg_pkg::WIDE_DW-1:0] hwpe_data_i,
  output logic                         hwpe_gnt_o,
  output logic                         hwpe_r_valid_o,
  output logic [hci_cfg_pkg::WIDE_DW-1:0]      hwpe_r_data_o,

  // narrow core port
  input  wire logic                    log_req_i,
  input  wire hci_types_pkg::hci_op_e  log_op_i,
  input  wire logic [hci_cfg_pkg::ADDR_W-1:0] log_add_i,
  input  wire logic [hci_cfg_pkg::BE_W-1:0]   log_be_i,
  input  wire logic [hci_cfg_pkg::WORD_W-1:0] log_data_i,
  output logic                         log_gnt_o,
  output logic                         log_r_valid_o,
  output logic [hci_cfg_pkg::WORD_W-1:0]      log_r_data_o
);

  // router side
  logic [hci_cfg_pkg::NB_BANKS-1:0]                         hwpe_bank_req;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] hwpe_bank_row;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  hwpe_bank_be;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] hwpe_bank_wdata;
  hci_types_pkg::hci_op_e                                  hwpe_bank_op;

  // decoder side
  logic [hci_cfg_pkg::NB_BANKS-1:0]                         log_bank_req;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] log_bank_row;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  log_bank_be;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] log_bank_wdata;
  hci_types_pkg::hci_op_e                                  log_bank_op;

  logic hwpe_grant;
  logic log_grant;

  // merged bank inputs and the shared read data
  logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_req;
  logic [hci_cfg_pkg::NB_BANKS-1:0]                         bank_we;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::ROW_W-1:0] bank_row;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::BE_W-1:0]  bank_be;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_wdata;
  logic [hci_cfg_pkg::NB_BANKS-1:0][hci_cfg_pkg::WORD_W-1:0] bank_rdata;

  hci_router u_router (
    .clk_i          ( clk_i           ),
    .rst_ni         ( rst_ni          ),
    .clear_i        ( clear_i         ),
    .hwpe_req_i     ( hwpe_req_i      ),
    .hwpe_op_i      ( hwpe_op_i       ),
    .hwpe_add_i     ( hwpe_add_i      ),
    .hwpe_be_i      ( hwpe_be_i       ),
    .hwpe_data_i    ( hwpe_data_i     ),
    .hwpe_gnt_o     ( hwpe_gnt_o      ),
    .hwpe_r_valid_o ( hwpe_r_valid_o  ),
    .hwpe_r_data_o  ( hwpe_r_data_o   ),
    .grant_i        ( hwpe_grant      ),
    .bank_rdata_i   ( bank_rdata      ),
    .bank_req_o     ( hwpe_bank_req   ),
    .bank_row_o     ( hwpe_bank_row   ),
    .bank_be_o      ( hwpe_bank_be    ),
    .bank_wdata_o   ( hwpe_bank_wdata ),
    .bank_op_o      ( hwpe_bank_op    )
  );

  hci_log_decoder u_log_decoder (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( clear_i        ),
    .log_req_i     ( log_req_i      ),
    .log_op_i      ( log_op_i       ),
    .log_add_i     ( log_add_i      ),
    .log_be_i      ( log_be_i       ),
    .log_data_i    ( log_data_i     ),
    .log_gnt_o     ( log_gnt_o      ),
    .log_r_valid_o ( log_r_valid_o  ),
    .log_r_data_o  ( log_r_data_o   ),
    .grant_i       ( log_grant      ),
    .bank_rdata_i  ( bank_rdata     ),
    .bank_req_o    ( log_bank_req   ),
    .bank_row_o    ( log_bank_row   ),
    .bank_be_o     ( log_bank_be    ),
    .bank_wdata_o  ( log_bank_wdata ),
    .bank_op_o     ( log_bank_op    )
  );

  hci_bank_arbiter u_bank_arbiter (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .hwpe_req_i   ( hwpe_bank_req   ),
    .hwpe_row_i   ( hwpe_bank_row   ),
    .hwpe_be_i    ( hwpe_bank_be    ),
    .hwpe_wdata_i ( hwpe_bank_wdata ),
    .hwpe_op_i    ( hwpe_bank_op    ),
    .log_req_i    ( log_bank_req    ),
    .log_row_i    ( log_bank_row    ),
    .log_be_i     ( log_bank_be     ),
    .log_wdata_i  ( log_bank_wdata  ),
    .log_op_i     ( log_bank_op     ),
    .hwpe_grant_o ( hwpe_grant      ),
    .log_grant_o  ( log_grant       ),
    .bank_req_o   ( bank_req        ),
    .bank_we_o    ( bank_we         ),
    .bank_row_o   ( bank_row        ),
    .bank_be_o    ( bank_be         ),
    .bank_wdata_o ( bank_wdata      )
  );

  // word-interleaved banks, bank b holds word indices with low bits equal to b
  for (genvar b = 0; b < hci_cfg_pkg::NB_BANKS; b++) begin : g_bank
    tcdm_bank u_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .we_i    ( bank_we[b]    ),
      .row_i   ( bank_row[b]   ),
      .be_i    ( bank_be[b]    ),
      .wdata_i ( bank_wdata[b] ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

`default_nettype wire

//--- verif/tb_hci_tasks.svh
`ifndef TB_HCI_TASKS_SVH
`define TB_HCI_TASKS_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_bit();
  logic fb;
  fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
  lfsr = {lfsr[14:0], fb};
  return fb;
endfunction

// n random bits, one lfsr step per bit
function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// lane 0 filled first
function automatic logic [hci_cfg_pkg::WIDE_DW-1:0] rand_wide();
  logic [hci_cfg_pkg::WIDE_DW-1:0] v;
  for (int k = 0; k < hci_cfg_pkg::NB_LANES; k++) begin
    v[32*k +: 32] = rand_bits(32);
  end
  return v;
endfunction

task automatic apply_reset();
  @(negedge clk_i);
  rst_ni = 1'b0;
  repeat (16) @(negedge clk_i);
  rst_ni = 1'b1;
endtask

// one narrow access, req held until gnt or timeout
task automatic narrow_access(input hci_types_pkg::hci_op_e op, input logic [31:0] add,
                             input logic [3:0] be, input logic [31:0] data);
  int unsigned waited;
  waited = 0;
  @(negedge clk_i);
  log_req_i  = 1'b1;
  log_op_i   = op;
  log_add_i  = add;
  log_be_i   = be;
  log_data_i = data;
  @(posedge clk_i);
  while (!log_gnt_o && waited < GNT_TIMEOUT) begin
    waited++;
    @(posedge clk_i);
  end
  if (!log_gnt_o) begin
    $display("narrow port got no grant within %0d cycles, address 0x%h", GNT_TIMEOUT, add);
    errors++;
    @(negedge clk_i);
    log_req_i = 1'b0;
  end
endtask

// one wide access of four lanes, same waiting rule
task automatic wide_access(input hci_types_pkg::hci_op_e op, input logic [31:0] add,
                           input logic [15:0] be, input logic [127:0] data);
  int unsigned waited;
  waited = 0;
  @(negedge clk_i);
  hwpe_req_i  = 1'b1;
  hwpe_op_i   = op;
  hwpe_add_i  = add;
  hwpe_be_i   = be;
  hwpe_data_i = data;
  @(posedge clk_i);
  while (!hwpe_gnt_o && waited < GNT_TIMEOUT) begin
    waited++;
    @(posedge clk_i);
  end
  if (!hwpe_gnt_o) begin
    $display("wide port got no grant within %0d cycles, address 0x%h", GNT_TIMEOUT, add);
    errors++;
    @(negedge clk_i);
    hwpe_req_i = 1'b0;
  end
endtask

// both ports start in the same cycle, each drops req once granted
task automatic both_access(input hci_types_pkg::hci_op_e wop, input logic [31:0] wadd,
                           input logic [15:0] wbe, input logic [127:0] wdata,
                           input hci_types_pkg::hci_op_e nop, input logic [31:0] nadd,
                           input logic [3:0] nbe, input logic [31:0] ndata);
  fork
    begin
      wide_access(wop, wadd, wbe, wdata);
      @(negedge clk_i);
      hwpe_req_i = 1'b0;
    end
    begin
      narrow_access(nop, nadd, nbe, ndata);
      @(negedge clk_i);
      log_req_i = 1'b0;
    end
  join
endtask

task automatic release_ports();
  @(negedge clk_i);
  hwpe_req_i = 1'b0;
  log_req_i  = 1'b0;
endtask

// drain the last response, then one line for the test
task automatic end_test(input string name);
  release_ports();
  repeat (2) @(negedge clk_i);
  tests_run++;
  if (errors != err_mark) begin
    tests_failed++;
    $display("test %0d failed: %s", tests_run, name);
  end else begin
    $display("test %0d passed: %s", tests_run, name);
  end
  err_mark = errors;
endtask

`endif

//--- verif/tb_hci_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_hci_subsystem;

  localparam int unsigned GNT_TIMEOUT = 20;
  localparam int unsigned WIDX_W      = hci_cfg_pkg::BANK_SEL_W + hci_cfg_pkg::ROW_W;
  localparam int unsigned MEM_BYTES   = hci_cfg_pkg::NB_BANKS * hci_cfg_pkg::BANK_DEPTH * 4;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               clear_i;
  logic                               hwpe_req_i;
  hci_types_pkg::hci_op_e             hwpe_op_i;
  logic [hci_cfg_pkg::ADDR_W-1:0]     hwpe_add_i;
  logic [hci_cfg_pkg::WIDE_BW-1:0]    hwpe_be_i;
  logic [hci_cfg_pkg::WIDE_DW-1:0]    hwpe_data_i;
  logic                               hwpe_gnt_o;
  logic                               hwpe_r_valid_o;
  logic [hci_cfg_pkg::WIDE_DW-1:0]    hwpe_r_data_o;
  logic                               log_req_i;
  hci_types_pkg::hci_op_e             log_op_i;
  logic [hci_cfg_pkg::ADDR_W-1:0]     log_add_i;
  logic [hci_cfg_pkg::BE_W-1:0]       log_be_i;
  logic [hci_cfg_pkg::WORD_W-1:0]     log_data_i;
  logic                               log_gnt_o;
  logic                               log_r_valid_o;
  logic [hci_cfg_pkg::WORD_W-1:0]     log_r_data_o;

  // reference memory with one byte per entry
  logic [7:0] ref_mem [MEM_BYTES];

  // what the response one cycle after gnt must look like
  logic                               log_pend;
  logic                               log_rd;
  logic [hci_cfg_pkg::WORD_W-1:0]     log_exp;
  logic                               hwpe_pend;
  logic                               hwpe_rd;
  logic [hci_cfg_pkg::WIDE_DW-1:0]    hwpe_exp;
  // narrow port owns the next clash
  logic                               log_wins;
  logic                               clash;

  logic [15:0]  lfsr;
  int unsigned  errors;
  int unsigned  err_mark;
  int unsigned  tests_run;
  int unsigned  tests_failed;

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  hci_subsystem u_hci_subsystem (.*);

  `include "tb_hci_tasks.svh"

  function automatic logic [31:0] ref_read(input logic [WIDX_W-1:0] w);
    return {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}], ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
  endfunction

  task automatic ref_write(input logic [WIDX_W-1:0] w, input logic [3:0] be,
                           input logic [31:0] d);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[{w, 2'(b)}] = d[8*b +: 8];
      end
    end
  endtask

  // lane k reads word w+k and wraps over the whole memory
  function automatic logic [127:0] wide_read(input logic [WIDX_W-1:0] w);
    logic [127:0] v;
    for (int k = 0; k < 4; k++) begin
      v[32*k +: 32] = ref_read(WIDX_W'(w + k));
    end
    return v;
  endfunction

  // banks touched by a wide access where bank is the word index mod 8
  function automatic logic [7:0] wide_banks(input logic [31:0] add);
    logic [7:0] m;
    m = '0;
    for (int k = 0; k < 4; k++) begin
      m[3'(add[4:2] + k)] = 1'b1;
    end
    return m;
  endfunction

  always_comb begin
    clash = hwpe_req_i && log_req_i && ((wide_banks(hwpe_add_i) >> log_add_i[4:2]) & 8'd1) != 0;
  end

  // expectations are taken at each gnt before the write lands in the model
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      log_pend  <= 1'b0;
      hwpe_pend <= 1'b0;
      log_wins  <= 1'b1;
    end else begin
      log_pend  <= log_gnt_o & ~clear_i;
      hwpe_pend <= hwpe_gnt_o & ~clear_i;
      if (log_gnt_o) begin
        log_rd  <= (log_op_i == hci_types_pkg::HCI_READ);
        log_exp <= ref_read(log_add_i[WIDX_W+1:2]);
      end
      if (hwpe_gnt_o) begin
        hwpe_rd  <= (hwpe_op_i == hci_types_pkg::HCI_READ);
        hwpe_exp <= wide_read(hwpe_add_i[WIDX_W+1:2]);
      end
      if (log_gnt_o && log_op_i == hci_types_pkg::HCI_WRITE) begin
        ref_write(log_add_i[WIDX_W+1:2], log_be_i, log_data_i);
      end
      if (hwpe_gnt_o && hwpe_op_i == hci_types_pkg::HCI_WRITE) begin
        for (int k = 0; k < 4; k++) begin
          ref_write(WIDX_W'(hwpe_add_i[WIDX_W+1:2] + k), hwpe_be_i[4*k +: 4],
                    hwpe_data_i[32*k +: 32]);
        end
      end
      // the loser of a clash wins the next one and clear hands it back to narrow
      if (clear_i) begin
        log_wins <= 1'b1;
      end else if (clash) begin
        log_wins <= ~log_wins;
      end
    end
  end

  log_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      log_r_valid_o == log_pend)
    else begin
      $display("[FAIL] log_r_valid_o: got 0x%h, expected 0x%h",
               $sampled(log_r_valid_o), $sampled(log_pend));
      errors++;
    end

  hwpe_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hwpe_r_valid_o == hwpe_pend)
    else begin
      $display("[FAIL] hwpe_r_valid_o: got 0x%h, expected 0x%h",
               $sampled(hwpe_r_valid_o), $sampled(hwpe_pend));
      errors++;
    end

  log_data_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (log_pend && log_rd) |-> log_r_data_o === log_exp)
    else begin
      $display("[FAIL] log_r_data_o: got 0x%h, expected 0x%h",
               $sampled(log_r_data_o), $sampled(log_exp));
      errors++;
    end

  hwpe_data_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (hwpe_pend && hwpe_rd) |-> hwpe_r_data_o === hwpe_exp)
    else begin
      $display("[FAIL] hwpe_r_data_o: got 0x%h, expected 0x%h",
               $sampled(hwpe_r_data_o), $sampled(hwpe_exp));
      errors++;
    end

  // exactly one winner per clash
  clash_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      clash |-> (log_gnt_o == log_wins) && (hwpe_gnt_o == !log_wins))
    else begin
      $display("[FAIL] hwpe_gnt_o/log_gnt_o: got 0x%h, expected 0x%h",
               $sampled({hwpe_gnt_o, log_gnt_o}), $sampled({!log_wins, log_wins}));
      errors++;
    end

  // without a clash every request is granted and nothing else
  free_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !clash |-> (log_gnt_o == log_req_i) && (hwpe_gnt_o == hwpe_req_i))
    else begin
      $display("[FAIL] hwpe_gnt_o/log_gnt_o: got 0x%h, expected 0x%h",
               $sampled({hwpe_gnt_o, log_gnt_o}), $sampled({hwpe_req_i, log_req_i}));
      errors++;
    end

  initial begin
    logic [31:0]            wadd;
    logic [31:0]            nadd;
    hci_types_pkg::hci_op_e wop;
    hci_types_pkg::hci_op_e nop;
    lfsr         = 16'd16474;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    hwpe_req_i   = 1'b0;
    hwpe_op_i    = hci_types_pkg::HCI_READ;
    hwpe_add_i   = '0;
    hwpe_be_i    = '0;
    hwpe_data_i  = '0;
    log_req_i    = 1'b0;
    log_op_i     = hci_types_pkg::HCI_READ;
    log_add_i    = '0;
    log_be_i     = '0;
    log_data_i   = '0;
    apply_reset();

    // full write then partial overwrite then read back the merge
    narrow_access(hci_types_pkg::HCI_WRITE, 32'h40, 4'hf, 32'h1122_3344);
    narrow_access(hci_types_pkg::HCI_WRITE, 32'h40, 4'b0101, 32'haabb_ccdd);
    narrow_access(hci_types_pkg::HCI_READ, 32'h40, 4'h0, 32'h0);
    end_test("narrow write and read with partial byte enables");

    // at offset 0 lane k lands on word 32+k
    wide_access(hci_types_pkg::HCI_WRITE, 32'h80, 16'hffff,
                128'h4444_4444_3333_3333_2222_2222_1111_1111);
    release_ports();
    for (int k = 0; k < 4; k++) begin
      narrow_access(hci_types_pkg::HCI_READ, 32'h80 + 4 * k, 4'h0, 32'h0);
    end
    end_test("wide write read back by narrow port");

    // offsets 5 to 7 wrap lanes past bank 7 into the next row
    for (int off = 5; off <= 7; off++) begin
      wadd = (64 + off) * 4;
      wide_access(hci_types_pkg::HCI_WRITE, wadd, 16'hffff, rand_wide());
      wide_access(hci_types_pkg::HCI_READ, wadd, 16'h0, '0);
      release_ports();
      for (int k = 0; k < 4; k++) begin
        narrow_access(hci_types_pkg::HCI_READ, wadd + 4 * k, 4'h0, 32'h0);
      end
      release_ports();
    end
    end_test("wide accesses wrapping into the next row");

    // word 96 covers banks 0 to 3 and word 98 sits in bank 2
    // word 69 in bank 5 holds data from the wrap test
    for (int i = 0; i < 3; i++) begin
      both_access(hci_types_pkg::HCI_WRITE, 32'h180, 16'hffff, rand_wide(),
                  hci_types_pkg::HCI_WRITE, 32'h188, 4'hf, rand_bits(32));
    end
    both_access(hci_types_pkg::HCI_READ, 32'h180, 16'h0, '0,
                hci_types_pkg::HCI_READ, 32'h114, 4'h0, 32'h0);
    end_test("bank conflicts alternate, disjoint banks both granted");

    // priority is with the wide port here and clear and reset hand it back
    @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    both_access(hci_types_pkg::HCI_READ, 32'h180, 16'h0, '0,
                hci_types_pkg::HCI_READ, 32'h184, 4'h0, 32'h0);
    apply_reset();
    repeat (2) @(negedge clk_i);
    both_access(hci_types_pkg::HCI_READ, 32'h180, 16'h0, '0,
                hci_types_pkg::HCI_READ, 32'h18c, 4'h0, 32'h0);
    end_test("priority after clear and reset");

    // words 0 to 63 get known contents first
    for (int i = 0; i < 16; i++) begin
      wide_access(hci_types_pkg::HCI_WRITE, i * 16, 16'hffff, rand_wide());
    end
    release_ports();
    for (int i = 0; i < 40; i++) begin
      wop  = rand_bits(1) ? hci_types_pkg::HCI_WRITE : hci_types_pkg::HCI_READ;
      wadd = (rand_bits(6) % 60) * 4;
      nop  = rand_bits(1) ? hci_types_pkg::HCI_WRITE : hci_types_pkg::HCI_READ;
      nadd = rand_bits(6) * 4;
      both_access(wop, wadd, 16'(rand_bits(16)), rand_wide(),
                  nop, nadd, 4'(rand_bits(4)), rand_bits(32));
    end
    end_test("random mixed traffic on both ports");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
design/hci_cfg_pkg.sv
design/hci_types_pkg.sv
design/tcdm_bank.sv
design/hci_router.sv
design/hci_log_decoder.sv
design/hci_bank_arbiter.sv
design/hci_subsystem.sv
verif/tb_hci_subsystem.sv
